// ==== cdr_macros.svh ====
`ifndef CDR_MACROS_SVH
`define CDR_MACROS_SVH

// Datapath widths
`define CDR_CODE_WIDTH   8
`define CDR_NUM_CHANNELS 16
`define CDR_NUM_PIS      4
`define CDR_PI_WIDTH     9  // Interpolator code wraps modulo 512

// Error sum covers 16 terms of up to +/-256 each
`define CDR_PD_WIDTH     14
`define CDR_PD_SHIFT     4

// Votes needed in one direction before a phase step
`define CDR_SLIDE_WIDTH  7

`endif

// ==== cdrPkg.sv ====
`include "cdr_macros.svh"

package cdrPkg;

    typedef logic signed [`CDR_CODE_WIDTH-1:0] code_t;

    // Channel 0 holds the oldest sample of the frame
    typedef struct packed {
        code_t [`CDR_NUM_CHANNELS-1:0] sample;
    } codeFrame_t;

    typedef logic signed [`CDR_PD_WIDTH-1:0] phaseErr_t;

    typedef struct packed {
        phaseErr_t err;
        logic      valid;
    } pdResult_t;

    // At most one of the two bits is set in any cycle
    typedef struct packed {
        logic early;
        logic late;
    } slipStep_t;

    typedef logic [`CDR_PI_WIDTH-1:0] piCode_t;

endpackage : cdrPkg

// ==== codeHistory.sv ====
`include "cdr_macros.svh"

module codeHistory (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire cdrPkg::codeFrame_t codes,
    input  wire logic               codesValid,
    output cdrPkg::codeFrame_t      curFrame,
    output cdrPkg::codeFrame_t      prevFrame,
    output logic                    histValid
);

    // Two frame deep shift register, advanced only by the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            curFrame  <= '0;
            prevFrame <= '0;
            histValid <= 1'b0;
        end else begin
            histValid <= codesValid;  // One pulse per accepted frame
            if (codesValid) begin
                prevFrame <= curFrame;
                curFrame  <= codes;
            end
        end
    end

endmodule : codeHistory

// ==== mmPhaseDetector.sv ====
`include "cdr_macros.svh"

module mmPhaseDetector (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire cdrPkg::codeFrame_t curFrame,
    input  wire cdrPkg::codeFrame_t prevFrame,
    input  wire logic               histValid,
    output cdrPkg::pdResult_t       pd
);

    localparam int NumCh = `CDR_NUM_CHANNELS;
    localparam int SignBit = `CDR_CODE_WIDTH - 1;

    cdrPkg::code_t     seq [NumCh:0];
    cdrPkg::phaseErr_t errSum;
    cdrPkg::phaseErr_t errShifted;
    cdrPkg::phaseErr_t errReg;
    logic              validReg;

    // Sample sequence in time order with one sample of history in front
    always_comb begin
        seq[0] = prevFrame.sample[NumCh-1];
        for (int k = 0; k < NumCh; k++) begin
            seq[k+1] = curFrame.sample[k];
        end
    end

    // Sum of x[n]*d[n-1] - x[n-1]*d[n] with d taken as the sign of each code
    always_comb begin : errSumCalc
        cdrPkg::phaseErr_t xNew;
        cdrPkg::phaseErr_t xOld;
        cdrPkg::phaseErr_t termNew;
        cdrPkg::phaseErr_t termOld;
        errSum = '0;
        for (int n = 1; n <= NumCh; n++) begin
            xNew    = seq[n];    // Sign extended into the wider sum
            xOld    = seq[n-1];
            termNew = seq[n-1][SignBit] ? -xNew : xNew;
            termOld = seq[n][SignBit] ? -xOld : xOld;
            errSum  = errSum + termNew - termOld;
        end
    end

    assign errShifted = errSum >>> `CDR_PD_SHIFT;  // Arithmetic, keeps the sign

    always_ff @(posedge clk) begin
        if (reset) begin
            validReg <= 1'b0;
        end else begin
            validReg <= histValid;
        end
    end

    always_ff @(posedge clk) begin
        if (histValid) begin
            errReg <= errShifted;
        end
    end

    assign pd.err   = errReg;
    assign pd.valid = validReg;

endmodule : mmPhaseDetector

// ==== slipVoter.sv ====
`include "cdr_macros.svh"

module slipVoter (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire cdrPkg::pdResult_t pd,
    output cdrPkg::slipStep_t      step
);

    localparam int CountWidth = $clog2(`CDR_SLIDE_WIDTH + 1) + 1;
    localparam logic signed [CountWidth-1:0] Threshold    = `CDR_SLIDE_WIDTH;
    localparam logic signed [CountWidth-1:0] NegThreshold = -`CDR_SLIDE_WIDTH;
    localparam logic signed [CountWidth-1:0] One          = 1;

    logic signed [CountWidth-1:0] count;
    logic signed [CountWidth-1:0] nextCount;
    logic                         errPos;
    logic                         errNeg;

    assign errNeg = pd.err[`CDR_PD_WIDTH-1];
    assign errPos = !errNeg && (pd.err != '0);

    always_comb begin
        nextCount = count;
        if (pd.valid && errPos) begin
            nextCount = count + One;
        end else if (pd.valid && errNeg) begin
            nextCount = count - One;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            step  <= '0;
        end else begin
            step <= '0;  // Steps are single cycle pulses
            if (nextCount == Threshold) begin
                step.late <= 1'b1;
                count     <= '0;
            end else if (nextCount == NegThreshold) begin
                step.early <= 1'b1;
                count      <= '0;
            end else begin
                count <= nextCount;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (count < Threshold) && (count > NegThreshold))
        else $error("Vote count escaped the threshold window");

endmodule : slipVoter

// ==== phaseIntegrator.sv ====
`include "cdr_macros.svh"

module phaseIntegrator (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire cdrPkg::slipStep_t step,
    output cdrPkg::piCode_t        piCtl [`CDR_NUM_PIS-1:0]
);

    // Even spacing of the interpolators around the phase circle
    localparam int Spacing = (1 << `CDR_PI_WIDTH) / `CDR_NUM_PIS;

    cdrPkg::piCode_t phaseAcc;

    // Natural wrap of the 9 bit register gives modulo 512
    always_ff @(posedge clk) begin
        if (reset) begin
            phaseAcc <= '0;
        end else if (step.late) begin
            phaseAcc <= phaseAcc + 1'b1;
        end else if (step.early) begin
            phaseAcc <= phaseAcc - 1'b1;
        end
    end

    for (genvar i = 0; i < `CDR_NUM_PIS; i++) begin : gPiOut
        assign piCtl[i] = phaseAcc + cdrPkg::piCode_t'(i * Spacing);  // Wraps as well
    end

    // Late has priority in the accumulator and would hide a simultaneous early step
    assert property (@(posedge clk) disable iff (reset) !(step.early && step.late))
        else $error("early and late arrived together");

endmodule : phaseIntegrator

// ==== cdr.sv ====
`include "cdr_macros.svh"

module cdr (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire cdrPkg::codeFrame_t codes,
    input  wire logic               codesValid,
    output cdrPkg::piCode_t         piCtl [`CDR_NUM_PIS-1:0]
);

    cdrPkg::codeFrame_t curFrame;
    cdrPkg::codeFrame_t prevFrame;
    logic               histValid;
    cdrPkg::pdResult_t  pd;
    cdrPkg::slipStep_t  step;

    // Frame history feeds the detector with one sample of lookback
    codeHistory i_codeHistory (
        .clk        (clk),
        .reset      (reset),
        .codes      (codes),
        .codesValid (codesValid),
        .curFrame   (curFrame),
        .prevFrame  (prevFrame),
        .histValid  (histValid)
    );

    mmPhaseDetector i_mmPhaseDetector (
        .clk       (clk),
        .reset     (reset),
        .curFrame  (curFrame),
        .prevFrame (prevFrame),
        .histValid (histValid),
        .pd        (pd)
    );

    slipVoter i_slipVoter (
        .clk   (clk),
        .reset (reset),
        .pd    (pd),
        .step  (step)
    );

    // Loop filter output drives all four interpolators
    phaseIntegrator i_phaseIntegrator (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .piCtl (piCtl)
    );

endmodule : cdr

// ==== tbClock.sv ====
module tbClock (
    input  logic resetReq,
    output logic clk,
    output logic reset
);

    localparam int HalfPeriod = 4;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Reset stays high for four rising edges at start and again on every request
    initial begin
        reset = 1'b1;
        forever begin
            repeat (4) @(posedge clk);
            #1 reset = 1'b0;
            @(posedge resetReq);
            reset = 1'b1;
        end
    end

endmodule : tbClock

// ==== tbCdr.sv ====
`include "cdr_macros.svh"

module tbCdr;

    localparam int NumCh      = `CDR_NUM_CHANNELS;
    localparam int NumPis     = `CDR_NUM_PIS;
    localparam int CodeWidth  = `CDR_CODE_WIDTH;
    localparam int PhaseMod   = 1 << `CDR_PI_WIDTH;
    localparam int Latency    = 4;
    localparam int DrainLimit = 16;
    localparam int ResetLimit = 20;

    typedef struct packed {
        int                       dueEdge;
        logic [`CDR_PI_WIDTH-1:0] phase;
    } expEntry_t;

    logic               clk;
    logic               reset;
    logic               resetReq = 1'b0;
    cdrPkg::codeFrame_t codes;
    logic               codesValid;
    cdrPkg::piCode_t    piCtl [NumPis-1:0];

    int          edgeCount = 0;
    int          modelPrevLast;
    int          modelCount;
    int          modelPhase;
    logic [31:0] lfsrState = 32'h6210c4bb;
    expEntry_t   expQueue [$];
    int          testErrors = 0;
    int          checkFails = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    bit          aborted = 1'b0;

    tbClock i_clock (
        .resetReq (resetReq),
        .clk      (clk),
        .reset    (reset)
    );

    cdr i_dut (
        .clk        (clk),
        .reset      (reset),
        .codes      (codes),
        .codesValid (codesValid),
        .piCtl      (piCtl)
    );

    always @(posedge clk) edgeCount <= edgeCount + 1;

    function automatic int codeValue(logic [CodeWidth-1:0] raw);
        return raw[CodeWidth-1] ? int'(raw) - (1 << CodeWidth) : int'(raw);
    endfunction

    function automatic int decision(int x);
        return (x >= 0) ? 1 : -1;  // Zero counts as a positive symbol
    endfunction

    // Galois LFSR, one step per bit handed out
    function automatic logic nextRandomBit();
        logic bitOut;
        bitOut = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (bitOut) begin
            lfsrState = lfsrState ^ 32'hD0000001;
        end
        return bitOut;
    endfunction

    function automatic int randomBits(int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            value = (value << 1) | int'(nextRandomBit());
        end
        return value;
    endfunction

    // Repeating magnitudes magA, magB, -magA, -magB give a steady error sign
    function automatic cdrPkg::codeFrame_t patternFrame(int magA, int magB);
        cdrPkg::codeFrame_t frame;
        int                 val;
        for (int k = 0; k < NumCh; k++) begin
            case (k % 4)
                0:       val = magA;
                1:       val = magB;
                2:       val = -magA;
                default: val = -magB;
            endcase
            frame.sample[k] = cdrPkg::code_t'(val);
        end
        return frame;
    endfunction

    task automatic modelReset();
        modelPrevLast = 0;
        modelCount = 0;
        modelPhase = 0;
        expQueue.delete();
    endtask

    // Detector, vote and integrator rules applied to one strobed frame
    task automatic modelApply(cdrPkg::codeFrame_t frame);
        int seq [NumCh+1];
        int errSum;
        int errOut;
        seq[0] = modelPrevLast;
        for (int k = 0; k < NumCh; k++) begin
            seq[k+1] = codeValue(frame.sample[k]);
        end
        errSum = 0;
        for (int n = 1; n <= NumCh; n++) begin
            errSum += seq[n] * decision(seq[n-1]) - seq[n-1] * decision(seq[n]);
        end
        errOut = errSum >>> `CDR_PD_SHIFT;
        if (errOut > 0) begin
            modelCount++;
        end else if (errOut < 0) begin
            modelCount--;
        end
        if (modelCount == `CDR_SLIDE_WIDTH) begin
            modelPhase = (modelPhase + 1) % PhaseMod;
            modelCount = 0;
        end else if (modelCount == -`CDR_SLIDE_WIDTH) begin
            modelPhase = (modelPhase + PhaseMod - 1) % PhaseMod;
            modelCount = 0;
        end
        modelPrevLast = seq[NumCh];
    endtask

    task automatic checkPi(int phase);
        int expCode;
        for (int i = 0; i < NumPis; i++) begin
            expCode = (phase + i * (PhaseMod / NumPis)) % PhaseMod;
            if (piCtl[i] !== cdrPkg::piCode_t'(expCode)) begin
                $display("MISMATCH time=%0t signal=piCtl[%0d] expected=%0d actual=%0d",
                         $time, i, expCode, piCtl[i]);
                testErrors++;
                checkFails++;
            end
        end
    endtask

    // One clock: check results that fall due, then drive the next inputs
    task automatic stepCycle(cdrPkg::codeFrame_t frame, logic valid);
        expEntry_t entry;
        @(posedge clk);
        #1;
        while (expQueue.size() > 0 && expQueue[0].dueEdge <= edgeCount) begin
            checkPi(int'(expQueue[0].phase));
            void'(expQueue.pop_front());
        end
        codes = frame;
        codesValid = valid;
        if (valid) begin
            modelApply(frame);
            entry.dueEdge = edgeCount + Latency;
            entry.phase = modelPhase[`CDR_PI_WIDTH-1:0];
            expQueue.push_back(entry);
        end
    endtask

    task automatic sendFrames(cdrPkg::codeFrame_t frame, int count);
        repeat (count) stepCycle(frame, 1'b1);
    endtask

    task automatic drainPipe();
        int waited;
        waited = 0;
        while (expQueue.size() > 0 && !aborted) begin
            if (waited == DrainLimit) begin
                $display("Timeout: results still pending after %0d idle cycles", DrainLimit);
                aborted = 1'b1;
            end else begin
                stepCycle('0, 1'b0);
                waited++;
            end
        end
    endtask

    task automatic waitResetRelease();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (reset && waited < ResetLimit);
        if (reset) begin
            $display("Timeout: reset still high after %0d cycles", ResetLimit);
            aborted = 1'b1;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        codes = '0;
        codesValid = 1'b0;
        resetReq = 1'b1;
        @(negedge clk);
        resetReq = 1'b0;
        waitResetRelease();
        modelReset();
    endtask

    task automatic finishTest(string name);
        if (testErrors == 0 && !aborted) begin
            testsPassed++;
            $display("Test %s: PASS", name);
        end else begin
            testsFailed++;
            $display("Test %s: FAIL with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic testResetState();
        waitResetRelease();
        modelReset();
        if (!aborted) checkPi(0);
        finishTest("resetState");
    endtask

    task automatic testLateDrift();
        applyReset();
        sendFrames(patternFrame(10, 50), 6);
        drainPipe();
        if (!aborted) checkPi(0);  // Six votes are one short of a step
        stepCycle(patternFrame(10, 50), 1'b1);
        drainPipe();
        if (!aborted) checkPi(1);
        finishTest("lateDrift");
    endtask

    task automatic testEarlyWrap();
        applyReset();
        sendFrames(patternFrame(50, 10), 7);
        drainPipe();
        if (!aborted) checkPi(PhaseMod - 1);
        finishTest("earlyWrap");
    endtask

    task automatic testZeroError();
        int startPhase;
        startPhase = modelPhase;
        sendFrames('0, 20);
        drainPipe();
        if (!aborted) checkPi(startPhase);
        finishTest("zeroError");
    endtask

    task automatic testGappedStrobes();
        int gap;
        repeat (20) begin
            gap = randomBits(3);
            repeat (gap) stepCycle(patternFrame(50, 10), 1'b0);  // Unstrobed data is ignored
            stepCycle(patternFrame(10, 50), 1'b1);
        end
        drainPipe();
        if (!aborted) checkPi(modelPhase);
        finishTest("gappedStrobes");
    endtask

    task automatic testRandomFrames();
        cdrPkg::codeFrame_t frame;
        repeat (200) begin
            for (int k = 0; k < NumCh; k++) begin
                frame.sample[k] = cdrPkg::code_t'(randomBits(CodeWidth));
            end
            stepCycle(frame, 1'b1);
        end
        drainPipe();
        finishTest("randomFrames");
    endtask

    initial begin
        codes = '0;
        codesValid = 1'b0;
        testResetState();
        if (!aborted) testLateDrift();
        if (!aborted) testEarlyWrap();
        if (!aborted) testZeroError();
        if (!aborted) testGappedStrobes();
        if (!aborted) testRandomFrames();
        $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 testsPassed, testsFailed, checkFails);
        if (!aborted && testsFailed == 0 && checkFails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tbCdr

// ==== sim.f ====
+incdir+.
cdrPkg.sv
codeHistory.sv
mmPhaseDetector.sv
slipVoter.sv
phaseIntegrator.sv
cdr.sv
tbClock.sv
tbCdr.sv
